//--- video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// counter widths and ranges
`define H_WIDTH     9
`define V_WIDTH     9
`define H_START     128
`define H_LAST      511
`define V_START     250
`define V_LAST      511

// line start strobe position
`define HINIT_POS   134

// blanking and sync positions
`define V_BLANK_ON  496
`define V_BLANK_OFF 271
`define VS_ON       507
`define VS_OFF      510
`define HS_ON       178
`define HS_OFF      206

// memory address widths
`define MAP_AW      10
`define ROM_AW      11
`define PAL_AW      4

// pixel ticks from timer to rgb output
`define PIPE_DELAY  16

`endif

//--- video_pkg.sv
package video_pkg;

    // memory selected by a host write
    typedef enum logic [1:0] {
        TGT_MAP = 2'd0,
        TGT_ROM = 2'd1,
        TGT_PAL = 2'd2
    } host_target_e;

    // fetch phase inside one 8-pixel cell, decoded from h[2:0]
    typedef enum logic [1:0] {
        FETCH_MAP   = 2'd0,
        FETCH_ROM   = 2'd1,
        FETCH_LOAD  = 2'd2,
        FETCH_SHIFT = 2'd3
    } fetch_state_e;

    // one tile map word, bank in the top two bits
    typedef struct packed {
        logic [1:0] bank;
        logic [7:0] code;
    } tile_entry_t;

    // palette index: bank selects a group of four colours
    typedef struct packed {
        logic [1:0] bank;
        logic [1:0] value;
    } pix_index_t;

    // 12-bit colour, red on top
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

//--- video_timing_if.sv
`timescale 1ns/1ns

interface video_timing_if;

    // raster position
    logic [8:0] h;
    logic [8:0] v;

    // one-tick strobes at line and frame start
    logic hinit;
    logic vinit;

    // blanking, active low, and object layer blanking
    logic lhbl;
    logic lhbl_obj;
    logic lvbl;

    // sync pulses, active high
    logic hs;
    logic vs;

    // driving stage
    modport source (
        output h, v, hinit, vinit,
        output lhbl, lhbl_obj, lvbl,
        output hs, vs
    );

    // receiving stage
    modport sink (
        input h, v, hinit, vinit,
        input lhbl, lhbl_obj, lvbl,
        input hs, vs
    );

endinterface

//--- video_timer.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_timer #(
    // object blanking advance in pixels
    parameter int obj_offset = 3
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           pxl_cen,
    video_timing_if.source tim
);

    localparam logic [`H_WIDTH-1:0] H_START     = `H_START;
    localparam logic [`H_WIDTH-1:0] H_LAST      = `H_LAST;
    localparam logic [`H_WIDTH-1:0] HINIT_POS   = `HINIT_POS;
    localparam logic [`H_WIDTH-1:0] HS_ON       = `HS_ON;
    localparam logic [`H_WIDTH-1:0] HS_OFF      = `HS_OFF;
    localparam logic [`V_WIDTH-1:0] V_START     = `V_START;
    localparam logic [`V_WIDTH-1:0] V_LAST      = `V_LAST;
    localparam logic [`V_WIDTH-1:0] V_BLANK_ON  = `V_BLANK_ON;
    localparam logic [`V_WIDTH-1:0] V_BLANK_OFF = `V_BLANK_OFF;
    localparam logic [`V_WIDTH-1:0] VS_ON       = `VS_ON;
    localparam logic [`V_WIDTH-1:0] VS_OFF      = `VS_OFF;

    // char layer blanking edges, both on cell ends
    localparam int LHBL_FALL = `H_START + 7;
    localparam int LHBL_RISE = (1 << (`H_WIDTH - 1)) + 7;

    // object blanking runs obj_offset pixels ahead
    localparam int OBJ_RISE = LHBL_RISE - obj_offset;
    localparam int OBJ_FALL_RAW = LHBL_FALL - obj_offset;
    // fall before line start wraps to the top of the line
    localparam int OBJ_FALL = (OBJ_FALL_RAW < `H_START) ?
        OBJ_FALL_RAW + (`H_LAST + 1 - `H_START) : OBJ_FALL_RAW;
    localparam logic [`H_WIDTH-1:0] OBJ_RISE_H = OBJ_RISE[`H_WIDTH-1:0];
    localparam logic [`H_WIDTH-1:0] OBJ_FALL_H = OBJ_FALL[`H_WIDTH-1:0];

    logic cell_end;

    // last pixel of an 8-pixel cell
    assign cell_end = &tim.h[2:0];

    // h/v counters and start strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            tim.h     <= H_START;
            tim.v     <= V_START;
            tim.hinit <= 1'b0;
            tim.vinit <= 1'b1;
        end else if (pxl_cen) begin
            tim.hinit <= tim.h == HINIT_POS;
            if (tim.h == H_LAST) begin
                tim.h     <= H_START;
                // new frame after the last line
                tim.vinit <= tim.v == V_LAST;
                tim.v     <= (tim.v == V_LAST) ? V_START : tim.v + 1'b1;
            end else begin
                tim.h <= tim.h + 1'b1;
            end
        end
    end

    // blanking and sync
    always_ff @(posedge clk) begin
        if (rst) begin
            tim.lhbl     <= 1'b0;
            tim.lhbl_obj <= 1'b0;
            tim.lvbl     <= 1'b0;
            tim.hs       <= 1'b0;
            tim.vs       <= 1'b0;
        end else if (pxl_cen) begin
            if (tim.h == OBJ_RISE_H) tim.lhbl_obj <= 1'b1;
            if (tim.h == OBJ_FALL_H) tim.lhbl_obj <= 1'b0;
            if (cell_end) begin
                // active while h is in the upper half
                tim.lhbl <= tim.h[`H_WIDTH-1];
                if (tim.v == V_BLANK_ON) tim.lvbl <= 1'b0;
                if (tim.v == V_BLANK_OFF) tim.lvbl <= 1'b1;
                if (tim.v == VS_ON) tim.vs <= 1'b1;
                if (tim.v == VS_OFF) tim.vs <= 1'b0;
            end
            if (tim.h == HS_ON) tim.hs <= 1'b1;
            if (tim.h == HS_OFF) tim.hs <= 1'b0;
        end
    end

endmodule

//--- char_fetch.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module char_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     host_we,
    input  video_pkg::host_target_e  host_target,
    input  logic [10:0]              host_addr,
    input  logic [15:0]              host_data,
    video_timing_if.sink             tim_in,
    video_timing_if.source           tim_out,
    output video_pkg::pix_index_t    pix
);

    // palette_out adds the last tick
    localparam int DEPTH = `PIPE_DELAY - 1;
    // h, v and seven single-bit timing signals
    localparam int TW = `H_WIDTH + `V_WIDTH + 7;
    localparam logic [`V_WIDTH-1:0] V_BLANK_OFF = `V_BLANK_OFF;

    video_pkg::tile_entry_t tile_map [0:(1 << `MAP_AW)-1];
    logic [15:0]            char_rom [0:(1 << `ROM_AW)-1];

    video_pkg::fetch_state_e state;
    logic [`V_WIDTH-1:0]     vrow;
    video_pkg::tile_entry_t  map_q;
    logic [15:0]             rom_q;
    logic [1:0]              bank_q;
    logic [15:0]             shifter;
    logic [1:0]              bank_sh;
    logic [TW-1:0]           dly [0:DEPTH-1];

    // host writes on any clock
    always_ff @(posedge clk) begin
        if (host_we && host_target == video_pkg::TGT_MAP) begin
            tile_map[host_addr[`MAP_AW-1:0]] <= host_data[9:0];
        end
        if (host_we && host_target == video_pkg::TGT_ROM) begin
            char_rom[host_addr[`ROM_AW-1:0]] <= host_data;
        end
    end

    // line inside the active field
    assign vrow = tim_in.v - V_BLANK_OFF;

    // phase in the cell from h
    always_comb begin
        case (tim_in.h[2:0])
            3'd5:    state = video_pkg::FETCH_MAP;
            3'd6:    state = video_pkg::FETCH_LOAD;
            3'd7:    state = video_pkg::FETCH_ROM;
            default: state = video_pkg::FETCH_SHIFT;
        endcase
    end

    // fetch for the current cell
    // result waits one cell before going to the shifter
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (state == video_pkg::FETCH_MAP) begin
                // row from v and column from h[7:3]
                map_q <= tile_map[{vrow[7:3], tim_in.h[7:3]}];
            end
            if (state == video_pkg::FETCH_ROM) begin
                rom_q  <= char_rom[{map_q.code, vrow[2:0]}];
                bank_q <= map_q.bank;
            end
        end
    end

    // pixel shifter with the leftmost pixel in the top two bits
    // loads the previous cell's row and shifts on all other ticks
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (state == video_pkg::FETCH_LOAD) begin
                shifter <= rom_q;
                bank_sh <= bank_q;
            end else begin
                shifter <= {shifter[13:0], 2'b00};
            end
        end
    end

    assign pix.bank  = bank_sh;
    assign pix.value = shifter[15:14];

    // timing delay line matching the pixel latency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                dly[i] <= '0;
            end
        end else if (pxl_cen) begin
            dly[0] <= {tim_in.h, tim_in.v, tim_in.hinit, tim_in.vinit, tim_in.lhbl,
                       tim_in.lhbl_obj, tim_in.lvbl, tim_in.hs, tim_in.vs};
            for (int i = 1; i < DEPTH; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign {tim_out.h, tim_out.v, tim_out.hinit, tim_out.vinit, tim_out.lhbl,
            tim_out.lhbl_obj, tim_out.lvbl, tim_out.hs, tim_out.vs} = dly[DEPTH-1];

endmodule

//--- palette_out.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module palette_out (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     host_we,
    input  video_pkg::host_target_e  host_target,
    input  logic [10:0]              host_addr,
    input  logic [15:0]              host_data,
    video_timing_if.sink             tim_in,
    input  video_pkg::pix_index_t    pix,
    output video_pkg::rgb_t          rgb,
    output logic                     lhbl,
    output logic                     lvbl,
    output logic                     hs,
    output logic                     vs
);

    // 16 colours, four banks of four
    video_pkg::rgb_t pal [0:(1 << `PAL_AW)-1];

    logic            active;
    video_pkg::rgb_t colour;

    // palette writes take the low 12 bits
    always_ff @(posedge clk) begin
        if (host_we && host_target == video_pkg::TGT_PAL) begin
            pal[host_addr[`PAL_AW-1:0]] <= host_data[11:0];
        end
    end

    // both blankings must be off
    assign active = tim_in.lhbl && tim_in.lvbl;

    // asynchronous lookup, a new entry shows on the next tick
    assign colour = pal[pix];

    // output register
    // colour and timing leave together
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb  <= '0;
            lhbl <= 1'b0;
            lvbl <= 1'b0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (pxl_cen) begin
            // black outside the active area
            rgb  <= active ? colour : '0;
            lhbl <= tim_in.lhbl;
            lvbl <= tim_in.lvbl;
            hs   <= tim_in.hs;
            vs   <= tim_in.vs;
        end
    end

endmodule

//--- video_top.sv
`timescale 1ns/1ns

module video_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     host_we,
    input  video_pkg::host_target_e  host_target,
    input  logic [10:0]              host_addr,
    input  logic [15:0]              host_data,
    output logic [8:0]               h,
    output logic [8:0]               v,
    output logic                     hinit,
    output logic                     vinit,
    output logic                     lhbl_obj,
    output video_pkg::rgb_t          rgb,
    output logic                     lhbl,
    output logic                     lvbl,
    output logic                     hs,
    output logic                     vs
);

    // timer output, and the copy in step with the pixels
    video_timing_if tim_raw ();
    video_timing_if tim_dly ();

    video_pkg::pix_index_t pix;

    video_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .tim     (tim_raw.source)
    );

    char_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .host_we     (host_we),
        .host_target (host_target),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .tim_in      (tim_raw.sink),
        .tim_out     (tim_dly.source),
        .pix         (pix)
    );

    palette_out u_palette (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .host_we     (host_we),
        .host_target (host_target),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .tim_in      (tim_dly.sink),
        .pix         (pix),
        .rgb         (rgb),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .hs          (hs),
        .vs          (vs)
    );

    // undelayed timing for the object layer
    assign h        = tim_raw.h;
    assign v        = tim_raw.v;
    assign hinit    = tim_raw.hinit;
    assign vinit    = tim_raw.vinit;
    assign lhbl_obj = tim_raw.lhbl_obj;

endmodule

//--- video_properties.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_properties (
    input logic       clk,
    input logic       rst,
    input logic [8:0] h,
    input logic       hinit,
    input logic       lhbl,
    input logic       hs
);

    // hinit follows h == HINIT_POS, so it only shows with the next h
    // one tick long since that h value comes once per line
    hinit_one_tick: assert property (@(posedge clk) disable iff (rst)
        hinit |-> h == `HINIT_POS + 1)
        else $error("hinit outside the tick after HINIT_POS");

    // counter never below the line start
    h_in_range: assert property (@(posedge clk) disable iff (rst)
        h >= `H_START)
        else $error("h out of range");

    // lhbl edges land as h enters a new cell
    lhbl_cell_end: assert property (@(posedge clk) disable iff (rst)
        !$stable(lhbl) |-> h[2:0] == 3'd0)
        else $error("lhbl changed inside a cell");

    // hs covers the 28 ticks after HS_ON up to HS_OFF
    hs_width: assert property (@(posedge clk) disable iff (rst)
        hs == (h > `HS_ON && h <= `HS_OFF))
        else $error("hs pulse has the wrong position or width");

endmodule

bind video_timer video_properties props (
    .clk     (clk),
    .rst     (rst),
    .h       (tim.h),
    .hinit   (tim.hinit),
    .lhbl    (tim.lhbl),
    .hs      (tim.hs)
);

//--- video_tb.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_tb;

    localparam int OBJ_OFFSET  = 3;
    localparam int LINE_PIX    = `H_LAST + 1 - `H_START;
    localparam int FRAME_LINES = `V_LAST + 1 - `V_START;
    localparam int FRAME_TICKS = LINE_PIX * FRAME_LINES;
    localparam int RUN_TICKS   = FRAME_TICKS + 1000;
    // lands mid frame inside the active lines
    localparam int REWRITE_AT  = 50000;
    // object blanking edges moved earlier by the offset
    localparam int OBJ_RISE    = 263 - OBJ_OFFSET;
    localparam int OBJ_FALL0   = 135 - OBJ_OFFSET;
    localparam int OBJ_FALL    = (OBJ_FALL0 < `H_START) ? OBJ_FALL0 + LINE_PIX : OBJ_FALL0;
    // two frames of 4 clocks per tick at 4 ns plus room for the loads
    localparam longint WATCHDOG_NS = 2 * FRAME_TICKS * 4 * 4 + 1000000;
    localparam int TBL_N = 24;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } hist_t;

    logic clk = 1'b0;
    logic rst;
    logic pxl_cen;
    logic host_we;
    video_pkg::host_target_e host_target;
    logic [10:0] host_addr;
    logic [15:0] host_data;
    logic [8:0]  h;
    logic [8:0]  v;
    logic hinit, vinit, lhbl_obj, lhbl, lvbl, hs, vs;
    video_pkg::rgb_t rgb;

    // target, address, data
    logic [28:0] load_table [0:TBL_N-1] = '{
        {2'd2, 11'd0, 16'h000}, {2'd2, 11'd1, 16'hf00}, {2'd2, 11'd2, 16'h0f0},
        {2'd2, 11'd3, 16'h00f}, {2'd2, 11'd4, 16'h111}, {2'd2, 11'd5, 16'h822},
        {2'd2, 11'd6, 16'h2a4}, {2'd2, 11'd7, 16'h46c}, {2'd2, 11'd8, 16'h999},
        {2'd2, 11'd9, 16'hc30}, {2'd2, 11'd10, 16'h3c0}, {2'd2, 11'd11, 16'h03c},
        {2'd2, 11'd12, 16'hfff}, {2'd2, 11'd13, 16'he71}, {2'd2, 11'd14, 16'h7e1},
        {2'd2, 11'd15, 16'h17e},
        {2'd1, 11'h008, 16'h1b1b}, {2'd1, 11'h009, 16'he4e4},
        {2'd1, 11'h00a, 16'hffff}, {2'd1, 11'h00b, 16'h5500},
        {2'd0, 11'h000, 16'h0301}, {2'd0, 11'h001, 16'h0101},
        {2'd0, 11'h010, 16'h0201}, {2'd0, 11'h3ff, 16'h0001}
    };

    // mirrors of the DUT memories
    logic [9:0]      map_m [0:1023];
    logic [15:0]     rom_m [0:2047];
    video_pkg::rgb_t pal_m [0:15];

    // timer model
    logic [8:0] mh, mv;
    logic mhinit, mvinit, mlhbl, mobj, mlvbl, mhs, mvs;

    hist_t hist [0:`PIPE_DELAY-1];
    int    wp;
    logic [31:0] seed;

    video_top uut (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .host_we(host_we),
        .host_target(host_target), .host_addr(host_addr), .host_data(host_data),
        .h(h), .v(v), .hinit(hinit), .vinit(vinit), .lhbl_obj(lhbl_obj),
        .rgb(rgb), .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input logic [8:0] got,
                               input logic [8:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_rgb(input string name, input video_pkg::rgb_t got,
                             input video_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // one host port write on a clock without pxl_cen
    task automatic write_host(input video_pkg::host_target_e tgt, input logic [10:0] addr,
                              input logic [15:0] data);
        @(negedge clk);
        host_we     = 1'b1;
        host_target = tgt;
        host_addr   = addr;
        host_data   = data;
        @(negedge clk);
        host_we = 1'b0;
        case (tgt)
            video_pkg::TGT_MAP: map_m[addr[9:0]] = data[9:0];
            video_pkg::TGT_ROM: rom_m[addr] = data;
            default:            pal_m[addr[3:0]] = data[11:0];
        endcase
    endtask

    // colour expected for a position seen PIPE_DELAY ticks ago
    function automatic video_pkg::rgb_t expected_rgb(input hist_t p);
        logic [8:0]  vrow;
        logic [9:0]  ent;
        logic [15:0] row;
        logic [1:0]  pixv;
        if (!(p.lhbl && p.lvbl)) begin
            return '0;
        end
        vrow = p.v - 9'(`V_BLANK_OFF);
        ent  = map_m[{vrow[7:3], p.h[7:3]}];
        row  = rom_m[{ent[7:0], vrow[2:0]}];
        // leftmost pixel in the top bits
        pixv = row[15 - 2 * p.h[2:0] -: 2];
        return pal_m[{ent[9:8], pixv}];
    endfunction

    // advance the model by one pixel tick from the timing rules
    task automatic step_model;
        logic [8:0] oh;
        logic [8:0] ov;
        oh = mh;
        ov = mv;
        mhinit = (oh == `HINIT_POS);
        if (oh == `H_LAST) begin
            mh     = 9'(`H_START);
            mvinit = (ov == `V_LAST);
            mv     = (ov == `V_LAST) ? 9'(`V_START) : ov + 9'd1;
        end else begin
            mh = oh + 9'd1;
        end
        if (oh[2:0] == 3'd7) begin
            mlhbl = oh[8];
            if (ov == `V_BLANK_ON) mlvbl = 1'b0;
            if (ov == `V_BLANK_OFF) mlvbl = 1'b1;
            if (ov == `VS_ON) mvs = 1'b1;
            if (ov == `VS_OFF) mvs = 1'b0;
        end
        if (oh == `HS_ON) mhs = 1'b1;
        if (oh == `HS_OFF) mhs = 1'b0;
        if (oh == OBJ_RISE) mobj = 1'b1;
        if (oh == OBJ_FALL) mobj = 1'b0;
    endtask

    // one pixel tick and a compare at the following falling edge
    task automatic run_tick;
        hist_t old;
        @(negedge clk);
        pxl_cen = 1'b1;
        @(negedge clk);
        pxl_cen = 1'b0;
        step_model();
        check_count("h", h, mh);
        check_count("v", v, mv);
        check_bit("hinit", hinit, mhinit);
        check_bit("vinit", vinit, mvinit);
        check_bit("lhbl_obj", lhbl_obj, mobj);
        old = hist[wp];
        check_bit("lhbl", lhbl, old.lhbl);
        check_bit("lvbl", lvbl, old.lvbl);
        check_bit("hs", hs, old.hs);
        check_bit("vs", vs, old.vs);
        check_rgb("rgb", rgb, expected_rgb(old));
        hist[wp] = {mh, mv, mlhbl, mlvbl, mhs, mvs};
        wp = (wp + 1) % `PIPE_DELAY;
        @(negedge clk);
        @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        host_we     = 1'b0;
        host_target = video_pkg::TGT_MAP;
        host_addr   = '0;
        host_data   = '0;
        seed        = 32'h3bd02bd3;
        wp          = 0;
        for (int i = 0; i < `PIPE_DELAY; i++) begin
            hist[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // reset state with the timer frozen while pxl_cen is low
        check_count("h", h, 9'd128);
        check_count("v", v, 9'd250);
        check_bit("vinit", vinit, 1'b1);
        check_bit("hinit", hinit, 1'b0);
        check_bit("lhbl", lhbl, 1'b0);
        check_bit("lvbl", lvbl, 1'b0);
        check_rgb("rgb", rgb, '0);
        mh = 9'd128;
        mv = 9'd250;
        {mhinit, mlhbl, mobj, mlvbl, mhs, mvs} = '0;
        mvinit = 1'b1;
        // random background for map and ROM
        for (int a = 0; a < 1024; a++) begin
            seed = lcg_next(seed);
            write_host(video_pkg::TGT_MAP, 11'(a), seed[31:16]);
        end
        for (int a = 0; a < 2048; a++) begin
            seed = lcg_next(seed);
            write_host(video_pkg::TGT_ROM, 11'(a), seed[31:16]);
        end
        for (int i = 0; i < TBL_N; i++) begin
            write_host(video_pkg::host_target_e'(load_table[i][28:27]),
                       load_table[i][26:16], load_table[i][15:0]);
        end
        for (int t = 0; t < RUN_TICKS; t++) begin
            if (t == REWRITE_AT) begin
                // new colours mid frame
                for (int i = 0; i < 16; i++) begin
                    write_host(video_pkg::TGT_PAL, 11'(i), ~load_table[i][15:0]);
                end
            end
            run_tick();
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
video_pkg.sv
video_timing_if.sv
video_timer.sv
char_fetch.sv
palette_out.sv
video_top.sv
video_properties.sv
video_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video pipeline testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module video_tb -Mdir obj_dir -o video_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/video_tb > sim.log 2>&1
sim_status=$?

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
